/* sources.f */
txdat_pkg.sv
txdat_slot_if.sv
txdat_line_slots.sv
txdat_credit_counter.sv
txdat_ctrl.sv
txdat_flit_pack.sv
hnf_txdat.sv
tb_hnf_txdat_assertions.sv
tb_hnf_txdat.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_hnf_txdat -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi

/* tb_hnf_txdat.sv */
// table-driven testbench for the data channel transmitter
// transaction table is modelled by header arrays read through rd_idx
// lines with a no-credit mode must come first in the table

`default_nettype none

module tb_hnf_txdat;

    typedef enum int {crd_steady, crd_random, crd_none} crd_mode_e;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                line_valid;
    logic [txdat_pkg::idx_w-1:0]         line_idx;
    logic [2*txdat_pkg::beat_data_w-1:0] line_data;
    logic [2*txdat_pkg::beat_be_w-1:0]   line_be;
    logic [1:0]                          line_pe;
    logic                                full;
    logic [txdat_pkg::idx_w-1:0]         rd_idx;
    logic [txdat_pkg::nid_w-1:0]         tgtid;
    logic [txdat_pkg::txnid_w-1:0]       txnid;
    logic [txdat_pkg::opcode_w-1:0]      opcode;
    logic [txdat_pkg::resp_w-1:0]        resp;
    logic [txdat_pkg::resperr_w-1:0]     resperr;
    logic [txdat_pkg::txnid_w-1:0]       dbid;
    logic                                clr_valid;
    logic [txdat_pkg::idx_w-1:0]         clr_idx;
    logic                                lcrdv;
    logic                                flitv;
    logic [txdat_pkg::flit_w-1:0]        flit;

    // stimulus table, one row per line
    logic [txdat_pkg::idx_w-1:0]         tbl_idx [12];
    logic [2*txdat_pkg::beat_data_w-1:0] tbl_data [12];
    logic [2*txdat_pkg::beat_be_w-1:0]   tbl_be [12];
    logic [1:0]                          tbl_pe [12];
    crd_mode_e                           tbl_mode [12];

    // transaction table model
    logic [txdat_pkg::nid_w-1:0]         hdr_tgtid [2**txdat_pkg::idx_w];
    logic [txdat_pkg::txnid_w-1:0]       hdr_txnid [2**txdat_pkg::idx_w];
    logic [txdat_pkg::opcode_w-1:0]      hdr_opcode [2**txdat_pkg::idx_w];
    logic [txdat_pkg::resp_w-1:0]        hdr_resp [2**txdat_pkg::idx_w];
    logic [txdat_pkg::resperr_w-1:0]     hdr_resperr [2**txdat_pkg::idx_w];
    logic [txdat_pkg::txnid_w-1:0]       hdr_dbid [2**txdat_pkg::idx_w];

    // expected beats in send order
    logic [txdat_pkg::flit_w-1:0]        exp_flit_q [$];
    logic                                exp_last_q [$];
    logic [txdat_pkg::idx_w-1:0]         exp_idx_q [$];
    logic [txdat_pkg::flit_w-1:0]        exp_flit;
    logic                                exp_last;
    logic [txdat_pkg::idx_w-1:0]         exp_idx;

    crd_mode_e crd_mode = crd_none;
    int        grants = 0;
    int        flits_seen = 0;
    int        clr_seen = 0;
    int        cycles = 0;
    int        timeout_cycles;

    hnf_txdat i_hnf_txdat (.*);

    assign tgtid   = hdr_tgtid[rd_idx];
    assign txnid   = hdr_txnid[rd_idx];
    assign opcode  = hdr_opcode[rd_idx];
    assign resp    = hdr_resp[rd_idx];
    assign resperr = hdr_resperr[rd_idx];
    assign dbid    = hdr_dbid[rd_idx];

    always #2 clk = ~clk;

    task automatic report_mismatch(string name, logic [127:0] expected, logic [127:0] actual);
        $display("ERROR %s expected %h actual %h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic put_row(int r, logic [txdat_pkg::idx_w-1:0] idx, logic [1:0] pe,
                           crd_mode_e mode);
        tbl_idx[r]  = idx;
        tbl_pe[r]   = pe;
        tbl_mode[r] = mode;
    endtask

    // one clock, then drive inputs just after the edge
    task automatic next_cycle();
        bit give;
        @(posedge clk);
        #1;
        line_valid = 1'b0;
        case (crd_mode)
            crd_steady: give = 1'b1;
            crd_random: give = 1'($urandom);
            default:    give = 1'b0;
        endcase
        // keep the DUT at 15 credits or fewer
        if (grants - flits_seen >= 15) begin
            give = 1'b0;
        end
        lcrdv = give;
        if (give) begin
            grants++;
        end
    endtask

    function automatic logic [txdat_pkg::flit_w-1:0] build_flit(int r, bit hi);
        logic [txdat_pkg::flit_w-1:0] f;
        logic [txdat_pkg::idx_w-1:0]  i;
        i = tbl_idx[r];
        f = '0;
        f[txdat_pkg::flit_tgtid_lsb +: txdat_pkg::nid_w]       = hdr_tgtid[i];
        f[txdat_pkg::flit_srcid_lsb +: txdat_pkg::nid_w]       = txdat_pkg::hn_nid;
        f[txdat_pkg::flit_txnid_lsb +: txdat_pkg::txnid_w]     = hdr_txnid[i];
        if (hdr_opcode[i] == txdat_pkg::opc_compdata) begin
            f[txdat_pkg::flit_homenid_lsb +: txdat_pkg::nid_w] = txdat_pkg::hn_nid;
        end
        f[txdat_pkg::flit_opcode_lsb +: txdat_pkg::opcode_w]   = hdr_opcode[i];
        f[txdat_pkg::flit_resperr_lsb +: txdat_pkg::resperr_w] = hdr_resperr[i];
        f[txdat_pkg::flit_resp_lsb +: txdat_pkg::resp_w]       = hdr_resp[i];
        f[txdat_pkg::flit_dbid_lsb +: txdat_pkg::txnid_w]      = hdr_dbid[i];
        // upper half carries data id 2
        if (hi) begin
            f[txdat_pkg::flit_dataid_lsb +: txdat_pkg::dataid_w]  = txdat_pkg::dataid_hi;
            f[txdat_pkg::flit_be_lsb +: txdat_pkg::beat_be_w]     = tbl_be[r][15:8];
            f[txdat_pkg::flit_data_lsb +: txdat_pkg::beat_data_w] = tbl_data[r][127:64];
        end else begin
            f[txdat_pkg::flit_dataid_lsb +: txdat_pkg::dataid_w]  = txdat_pkg::dataid_lo;
            f[txdat_pkg::flit_be_lsb +: txdat_pkg::beat_be_w]     = tbl_be[r][7:0];
            f[txdat_pkg::flit_data_lsb +: txdat_pkg::beat_data_w] = tbl_data[r][63:0];
        end
        return f;
    endfunction

    // ----------------------------------------------------------------------
    // timeout and flit scoreboard
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                report_problem("timeout, the lines did not all leave in time");
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (flitv) begin
                if (exp_flit_q.size() == 0) begin
                    report_problem("a flit arrived while no beat was expected");
                end else begin
                    exp_flit = exp_flit_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    exp_idx  = exp_idx_q.pop_front();
                    flits_seen++;
                    assert (flit == exp_flit)
                        else report_mismatch("flit_fields", 128'(exp_flit), 128'(flit));
                    assert (flits_seen <= grants)
                        else report_mismatch("credit_count", 128'(grants), 128'(flits_seen));
                    assert (clr_valid == exp_last)
                        else report_mismatch("clr_valid", 128'(exp_last), 128'(clr_valid));
                    if (exp_last) begin
                        assert (clr_idx == exp_idx)
                            else report_mismatch("clr_idx", 128'(exp_idx), 128'(clr_idx));
                    end
                end
            end else begin
                assert (!clr_valid) else report_problem("clr_valid rose without a flit");
            end
            if (clr_valid) begin
                clr_seen++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(13817));
        rst        = 1'b1;
        line_valid = 1'b0;
        line_idx   = '0;
        line_data  = '0;
        line_be    = '0;
        line_pe    = 2'b00;
        lcrdv      = 1'b0;
        timeout_cycles = 40 * 12 + 100;

        for (int i = 0; i < 2**txdat_pkg::idx_w; i++) begin
            hdr_tgtid[i]   = 7'(i * 5 + 3);
            hdr_txnid[i]   = 8'(i * 17 + 1);
            hdr_opcode[i]  = (i % 4 == 0) ? txdat_pkg::opc_compdata : 4'(i) ^ 4'h8;
            hdr_resp[i]    = 3'(i);
            hdr_resperr[i] = 2'(i / 4);
            hdr_dbid[i]    = 8'(i + 192);
        end

        // idx, mask, credit mode
        put_row(0,  4'd3,  2'b11, crd_none);
        put_row(1,  4'd7,  2'b01, crd_none);
        put_row(2,  4'd4,  2'b10, crd_steady);
        put_row(3,  4'd9,  2'b11, crd_steady);
        put_row(4,  4'd0,  2'b01, crd_steady);
        put_row(5,  4'd12, 2'b11, crd_random);
        put_row(6,  4'd5,  2'b10, crd_random);
        put_row(7,  4'd15, 2'b01, crd_random);
        put_row(8,  4'd8,  2'b11, crd_random);
        put_row(9,  4'd2,  2'b11, crd_steady);
        put_row(10, 4'd11, 2'b10, crd_steady);
        put_row(11, 4'd6,  2'b11, crd_random);

        for (int r = 0; r < 12; r++) begin
            tbl_data[r] = {$urandom, $urandom, $urandom, $urandom};
            tbl_be[r]   = 16'($urandom);
            if (tbl_pe[r][0]) begin
                exp_flit_q.push_back(build_flit(r, 1'b0));
                exp_last_q.push_back(tbl_pe[r] == 2'b01);
                exp_idx_q.push_back(tbl_idx[r]);
            end
            if (tbl_pe[r][1]) begin
                exp_flit_q.push_back(build_flit(r, 1'b1));
                exp_last_q.push_back(1'b1);
                exp_idx_q.push_back(tbl_idx[r]);
            end
        end

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!flitv) else report_mismatch("reset_flitv", 128'(0), 128'(flitv));
        assert (!clr_valid) else report_mismatch("reset_clr_valid", 128'(0), 128'(clr_valid));
        assert (!full) else report_mismatch("reset_full", 128'(0), 128'(full));

        for (int r = 0; r < 12; r++) begin
            crd_mode = tbl_mode[r];
            while (full) begin
                next_cycle();
            end
            line_valid = 1'b1;
            line_idx   = tbl_idx[r];
            line_data  = tbl_data[r];
            line_be    = tbl_be[r];
            line_pe    = tbl_pe[r];
            next_cycle();
            // two lines held with no credit yet
            if (r > 0 && tbl_mode[r] == crd_none && tbl_mode[r-1] == crd_none) begin
                repeat (10) next_cycle();
                assert (full) else report_mismatch("backpressure_full", 128'(1), 128'(full));
                assert (flits_seen == 0)
                    else report_mismatch("no_credit_no_flit", 128'(0), 128'(flits_seen));
            end
        end

        crd_mode = crd_steady;
        while (exp_flit_q.size() != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
        assert (!full) else report_mismatch("full_after_drain", 128'(0), 128'(full));

        if (clr_seen == 12) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_mismatch("lines_released", 128'(12), 128'(clr_seen));
        end
    end

endmodule

`default_nettype wire

/* tb_hnf_txdat_assertions.sv */
// protocol checks on the transmitter ports, bound into hnf_txdat
// credit check assumes each flit spent a credit granted in an earlier cycle

`default_nettype none

module tb_hnf_txdat_assertions (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         line_valid,
    input  logic                         full,
    input  logic [1:0]                   line_pe,
    input  logic                         lcrdv,
    input  logic                         flitv,
    input  logic                         clr_valid,
    input  logic [txdat_pkg::idx_w-1:0]  clr_idx
);

    // credits granted so far minus flits seen so far
    logic [5:0] avail_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            avail_q <= '0;
        end else if (lcrdv && !flitv) begin
            avail_q <= avail_q + 6'd1;
        end else if (!lcrdv && flitv) begin
            avail_q <= avail_q - 6'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) line_valid |-> !full)
        else $error("line offered while both slots are held");

    assert property (@(posedge clk) disable iff (rst) flitv |-> avail_q != 6'd0)
        else $error("flit sent without an earlier credit");

    // back to back pulses only for different lines
    assert property (@(posedge clk) disable iff (rst)
        clr_valid |=> (!clr_valid || clr_idx != $past(clr_idx)))
        else $error("release pulse held for more than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        (line_valid && !full) |-> line_pe != 2'b00)
        else $error("line accepted with an empty beat mask");

endmodule

bind hnf_txdat tb_hnf_txdat_assertions i_txdat_assertions (
    .clk        (clk),
    .rst        (rst),
    .line_valid (line_valid),
    .full       (full),
    .line_pe    (line_pe),
    .lcrdv      (lcrdv),
    .flitv      (flitv),
    .clr_valid  (clr_valid),
    .clr_idx    (clr_idx)
);

`default_nettype wire

/* hnf_txdat.sv */
// home node data channel transmitter, up to two lines held
// transaction table must answer rd_idx combinationally
// full must be respected, a line offered while full is dropped

`default_nettype none

module hnf_txdat (
    input  logic                                clk,
    input  logic                                rst,

    // data buffer
    input  logic                                line_valid,
    input  logic [txdat_pkg::idx_w-1:0]         line_idx,
    input  logic [2*txdat_pkg::beat_data_w-1:0] line_data,
    input  logic [2*txdat_pkg::beat_be_w-1:0]   line_be,
    input  logic [1:0]                          line_pe,
    output logic                                full,

    // transaction table
    output logic [txdat_pkg::idx_w-1:0]         rd_idx,
    input  logic [txdat_pkg::nid_w-1:0]         tgtid,
    input  logic [txdat_pkg::txnid_w-1:0]       txnid,
    input  logic [txdat_pkg::opcode_w-1:0]      opcode,
    input  logic [txdat_pkg::resp_w-1:0]        resp,
    input  logic [txdat_pkg::resperr_w-1:0]     resperr,
    input  logic [txdat_pkg::txnid_w-1:0]       dbid,
    output logic                                clr_valid,
    output logic [txdat_pkg::idx_w-1:0]         clr_idx,

    // link
    input  logic                                lcrdv,
    output logic                                flitv,
    output logic [txdat_pkg::flit_w-1:0]        flit
);

    txdat_slot_if slot_bus ();

    logic credit_ok;
    logic consume;

    assign rd_idx = slot_bus.head_idx;

    txdat_line_slots i_line_slots (
        .clk        (clk),
        .rst        (rst),
        .line_valid (line_valid),
        .line_idx   (line_idx),
        .line_data  (line_data),
        .line_be    (line_be),
        .line_pe    (line_pe),
        .full       (full),
        .slot       (slot_bus.slots)
    );

    txdat_credit_counter i_credit_counter (
        .clk       (clk),
        .rst       (rst),
        .lcrdv     (lcrdv),
        .consume   (consume),
        .credit_ok (credit_ok)
    );

    txdat_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .credit_ok (credit_ok),
        .consume   (consume),
        .slot      (slot_bus.ctrl),
        .clr_valid (clr_valid),
        .clr_idx   (clr_idx)
    );

    txdat_flit_pack i_flit_pack (
        .clk     (clk),
        .rst     (rst),
        .send    (consume),
        .slot    (slot_bus.pack),
        .tgtid   (tgtid),
        .txnid   (txnid),
        .opcode  (opcode),
        .resp    (resp),
        .resperr (resperr),
        .dbid    (dbid),
        .flitv   (flitv),
        .flit    (flit)
    );

endmodule

`default_nettype wire

/* txdat_flit_pack.sv */
// packs header and current beat into a data flit, one register stage
// header inputs must be valid for the head index in the send cycle

`default_nettype none

module txdat_flit_pack (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             send,
    txdat_slot_if.pack                       slot,
    input  logic [txdat_pkg::nid_w-1:0]      tgtid,
    input  logic [txdat_pkg::txnid_w-1:0]    txnid,
    input  logic [txdat_pkg::opcode_w-1:0]   opcode,
    input  logic [txdat_pkg::resp_w-1:0]     resp,
    input  logic [txdat_pkg::resperr_w-1:0]  resperr,
    input  logic [txdat_pkg::txnid_w-1:0]    dbid,
    output logic                             flitv,
    output logic [txdat_pkg::flit_w-1:0]     flit
);

    logic [txdat_pkg::flit_w-1:0] flit_d;
    logic [txdat_pkg::nid_w-1:0]  homenid;

    // home node id only travels with compdata
    assign homenid = (opcode == txdat_pkg::opc_compdata) ? txdat_pkg::hn_nid : '0;

    always_comb begin
        flit_d = '0;
        flit_d[txdat_pkg::flit_tgtid_lsb   +: txdat_pkg::nid_w]       = tgtid;
        flit_d[txdat_pkg::flit_srcid_lsb   +: txdat_pkg::nid_w]       = txdat_pkg::hn_nid;
        flit_d[txdat_pkg::flit_txnid_lsb   +: txdat_pkg::txnid_w]     = txnid;
        flit_d[txdat_pkg::flit_homenid_lsb +: txdat_pkg::nid_w]       = homenid;
        flit_d[txdat_pkg::flit_opcode_lsb  +: txdat_pkg::opcode_w]    = opcode;
        flit_d[txdat_pkg::flit_resperr_lsb +: txdat_pkg::resperr_w]   = resperr;
        flit_d[txdat_pkg::flit_resp_lsb    +: txdat_pkg::resp_w]      = resp;
        flit_d[txdat_pkg::flit_dbid_lsb    +: txdat_pkg::txnid_w]     = dbid;
        flit_d[txdat_pkg::flit_dataid_lsb  +: txdat_pkg::dataid_w]    = slot.beat_dataid;
        flit_d[txdat_pkg::flit_be_lsb      +: txdat_pkg::beat_be_w]   = slot.beat_be;
        flit_d[txdat_pkg::flit_data_lsb    +: txdat_pkg::beat_data_w] = slot.beat_data;
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flitv <= 1'b0;
        end else begin
            flitv <= send;
        end
    end

    // flit holds its last value between sends
    always_ff @(posedge clk) begin
        if (send) begin
            flit <= flit_d;
        end
    end

endmodule

`default_nettype wire

/* txdat_ctrl.sv */
// send decision for the head beat and the buffer release pulse
// clr_valid lines up with the flitv of the line's last beat

`default_nettype none

module txdat_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         credit_ok,
    output logic                         consume,
    txdat_slot_if.ctrl                   slot,
    output logic                         clr_valid,
    output logic [txdat_pkg::idx_w-1:0]  clr_idx
);

    logic send;
    logic release_line;

    // one beat per cycle whenever a credit is there
    assign send         = slot.head_valid & credit_ok;
    assign release_line = send & slot.head_last;

    assign slot.advance = send;
    assign consume      = send;

    // ----------------------------------------------------------------------
    // release to the transaction table
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_valid <= 1'b0;
        end else begin
            clr_valid <= release_line;
        end
    end

    always_ff @(posedge clk) begin
        if (release_line) begin
            clr_idx <= slot.head_idx;
        end
    end

endmodule

`default_nettype wire

/* txdat_credit_counter.sv */
// link credit counter, at most 15 credits outstanding
// a credit arriving this cycle can be spent this cycle

`default_nettype none

module txdat_credit_counter (
    input  logic clk,
    input  logic rst,
    input  logic lcrdv,
    input  logic consume,
    output logic credit_ok
);

    logic [txdat_pkg::crd_cnt_w-1:0] cnt_q;
    logic [txdat_pkg::crd_cnt_w-1:0] cnt_d;

    // stored credit or one arriving right now
    assign credit_ok = (cnt_q != '0) | lcrdv;

    always_comb begin
        case ({lcrdv, consume})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            // grant and send together cancel out
            default: cnt_d = cnt_q;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

endmodule

`default_nettype wire

/* txdat_line_slots.sv */
// two line slots served in arrival order
// the sender must hold line_valid low while full is high
// a zero partial-enable mask is not supported

`default_nettype none

module txdat_line_slots (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         line_valid,
    input  logic [txdat_pkg::idx_w-1:0]  line_idx,
    input  txdat_pkg::line_u             line_data,
    input  txdat_pkg::line_be_u          line_be,
    input  logic [1:0]                   line_pe,
    output logic                         full,
    txdat_slot_if.slots                  slot
);

    logic [1:0]                   vld_q;
    logic [1:0]                   pend_q [2];
    logic                         wr_ptr_q;
    logic                         rd_ptr_q;
    logic [txdat_pkg::idx_w-1:0]  idx_q [2];
    txdat_pkg::line_u             data_q [2];
    txdat_pkg::line_be_u          be_q [2];

    logic                         accept;
    logic                         pop;
    logic [1:0]                   head_pend;

    assign full      = vld_q[0] & vld_q[1];
    assign accept    = line_valid & ~full;
    assign head_pend = pend_q[rd_ptr_q];
    assign pop       = slot.advance & slot.head_last;

    // ----------------------------------------------------------------------
    // slot state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q     <= 2'b00;
            pend_q[0] <= 2'b00;
            pend_q[1] <= 2'b00;
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
        end else begin
            // head line done, move on to the other slot
            if (pop) begin
                vld_q[rd_ptr_q]  <= 1'b0;
                pend_q[rd_ptr_q] <= 2'b00;
                rd_ptr_q         <= ~rd_ptr_q;
            end else if (slot.advance) begin
                pend_q[rd_ptr_q] <= {head_pend[1], 1'b0};
            end
            // write slot is never the head while the head is busy
            if (accept) begin
                vld_q[wr_ptr_q]  <= 1'b1;
                pend_q[wr_ptr_q] <= line_pe;
                wr_ptr_q         <= ~wr_ptr_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q[wr_ptr_q]       <= line_idx;
            data_q[wr_ptr_q].word <= line_data.word;
            be_q[wr_ptr_q].word   <= line_be.word;
        end
    end

    // ----------------------------------------------------------------------
    // current beat of the head line
    // ----------------------------------------------------------------------
    always_comb begin
        slot.head_valid = vld_q[rd_ptr_q];
        slot.head_idx   = idx_q[rd_ptr_q];
        // lower half goes first when pending
        if (head_pend[0]) begin
            slot.beat_data   = data_q[rd_ptr_q].beat[0];
            slot.beat_be     = be_q[rd_ptr_q].beat[0];
            slot.beat_dataid = txdat_pkg::dataid_lo;
        end else begin
            slot.beat_data   = data_q[rd_ptr_q].beat[1];
            slot.beat_be     = be_q[rd_ptr_q].beat[1];
            slot.beat_dataid = txdat_pkg::dataid_hi;
        end
        slot.head_last = ~(head_pend[0] & head_pend[1]);
    end

endmodule

`default_nettype wire

/* txdat_slot_if.sv */
// head-of-queue view of the line slots, shared with control and packer
// advance is the only signal going back into the slots

`default_nettype none

interface txdat_slot_if;

    logic                               head_valid;
    logic [txdat_pkg::idx_w-1:0]        head_idx;
    logic [txdat_pkg::beat_data_w-1:0]  beat_data;
    logic [txdat_pkg::beat_be_w-1:0]    beat_be;
    logic [txdat_pkg::dataid_w-1:0]     beat_dataid;
    logic                               head_last;
    logic                               advance;

    modport slots (
        output head_valid, head_idx, beat_data, beat_be, beat_dataid, head_last,
        input  advance
    );

    modport ctrl (
        input  head_valid, head_idx, head_last,
        output advance
    );

    modport pack (
        input  beat_data, beat_be, beat_dataid
    );

endinterface

`default_nettype wire

/* txdat_pkg.sv */
// shared widths, node ids and the line type of the data transmitter
// a line is two 64 bit beats, beat 0 being the lower half
// flit fields are packed from the lsb up, data first, target id on top

`default_nettype none

package txdat_pkg;

    // ----------------------------------------------------------------------
    // field widths
    // ----------------------------------------------------------------------
    localparam int beat_data_w = 64;
    localparam int beat_be_w   = 8;
    localparam int idx_w       = 4;
    localparam int nid_w       = 7;
    localparam int txnid_w     = 8;
    localparam int opcode_w    = 4;
    localparam int resp_w      = 3;
    localparam int resperr_w   = 2;
    localparam int dataid_w    = 2;
    localparam int crd_cnt_w   = 4;

    // ----------------------------------------------------------------------
    // node ids and codes
    // ----------------------------------------------------------------------
    localparam logic [nid_w-1:0]    hn_nid       = 7'h21;
    localparam logic [opcode_w-1:0] opc_compdata = 4'h4;
    localparam logic [dataid_w-1:0] dataid_lo    = 2'd0;
    localparam logic [dataid_w-1:0] dataid_hi    = 2'd2;

    // ----------------------------------------------------------------------
    // flit layout, lsb of each field
    // ----------------------------------------------------------------------
    localparam int flit_data_lsb    = 0;
    localparam int flit_be_lsb      = flit_data_lsb + beat_data_w;
    localparam int flit_dataid_lsb  = flit_be_lsb + beat_be_w;
    localparam int flit_dbid_lsb    = flit_dataid_lsb + dataid_w;
    localparam int flit_resp_lsb    = flit_dbid_lsb + txnid_w;
    localparam int flit_resperr_lsb = flit_resp_lsb + resp_w;
    localparam int flit_opcode_lsb  = flit_resperr_lsb + resperr_w;
    localparam int flit_homenid_lsb = flit_opcode_lsb + opcode_w;
    localparam int flit_txnid_lsb   = flit_homenid_lsb + nid_w;
    localparam int flit_srcid_lsb   = flit_txnid_lsb + txnid_w;
    localparam int flit_tgtid_lsb   = flit_srcid_lsb + nid_w;

    // 120 bits with the widths above
    localparam int flit_w = flit_tgtid_lsb + nid_w;

    // ----------------------------------------------------------------------
    // line types
    // ----------------------------------------------------------------------
    // whole line, or two beats with beat 0 in the low half
    typedef union packed {
        logic [2*beat_data_w-1:0]     word;
        logic [1:0][beat_data_w-1:0]  beat;
    } line_u;

    // byte enables of one line, same shape
    typedef union packed {
        logic [2*beat_be_w-1:0]       word;
        logic [1:0][beat_be_w-1:0]    beat;
    } line_be_u;

endpackage

`default_nettype wire
